/* cfg_loader_consts.svh */
/*
 * Counts, widths and buffer-kind codes of the setup-word loader.
 * CFG_SEQ_WIDTH must be a power of two, because the offset is split
 * into engine number and window position by bit slicing.
 * CFG_NUM_ENGINES must be at least 2, and CFG_NUM_WORDS may not
 * exceed CFG_SEQ_WIDTH.
 */
`ifndef CFG_LOADER_CONSTS_SVH
`define CFG_LOADER_CONSTS_SVH

// --------------------------------------------------
// Counts and widths
// --------------------------------------------------
`define CFG_NUM_ENGINES 4
`define CFG_SEQ_WIDTH   8
`define CFG_NUM_WORDS   7
`define CFG_DATA_W      32
`define CFG_OFFSET_W    8
`define CFG_FLAGS_W     5
`define CFG_KIND_W      3

// --------------------------------------------------
// Buffer kind codes
// --------------------------------------------------
`define CFG_KIND_NONE         3'd0
`define CFG_KIND_CU_SETUP     3'd1
`define CFG_KIND_ENGINE_SETUP 3'd2
`define CFG_KIND_VERTEX       3'd3
`define CFG_KIND_EDGE         3'd4

`endif

/* cfg_loader_pkg.sv */
/*
 * Types shared by the loader modules and the testbench.
 * Struct fields are listed MSB first. The array pointer is two data
 * words wide, high half taken from setup word 5.
 */
`include "cfg_loader_consts.svh"

package cfg_loader_pkg;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------
    typedef logic [`CFG_DATA_W-1:0]                 data_word_t;
    typedef logic [`CFG_OFFSET_W-1:0]               offset_t;
    typedef logic [$clog2(`CFG_SEQ_WIDTH)-1:0]      seq_pos_t;
    typedef logic [$clog2(`CFG_NUM_ENGINES)-1:0]    engine_id_t;
    typedef logic [`CFG_FLAGS_W-1:0]                mode_flags_t;
    typedef logic [2*`CFG_DATA_W-1:0]               array_ptr_t;

    // --------------------------------------------------
    // Enums
    // --------------------------------------------------
    typedef enum logic [`CFG_KIND_W-1:0] {
        KIND_NONE         = `CFG_KIND_NONE,
        KIND_CU_SETUP     = `CFG_KIND_CU_SETUP,
        KIND_ENGINE_SETUP = `CFG_KIND_ENGINE_SETUP,
        KIND_VERTEX       = `CFG_KIND_VERTEX,
        KIND_EDGE         = `CFG_KIND_EDGE
    } buffer_kind_e;

    typedef enum logic {
        ASM_COLLECT,
        ASM_HOLD
    } asm_state_e;

    // --------------------------------------------------
    // Structs
    // --------------------------------------------------
    typedef struct packed {
        buffer_kind_e kind;
        offset_t      offset;
        data_word_t   data;
    } response_word_t;

    typedef struct packed {
        seq_pos_t   pos;
        data_word_t data;
    } setup_word_t;

    // Flag bits: 0 increment, 1 decrement, 2 sequence, 3 buffer, 4 counter
    typedef struct packed {
        mode_flags_t flags;
        data_word_t  index_start;
        data_word_t  index_end;
        data_word_t  stride;
        array_ptr_t  array_ptr;
        data_word_t  array_size;
    } config_params_t;

    typedef struct packed {
        engine_id_t     engine;
        config_params_t params;
    } config_record_t;

endpackage

/* response_dispatcher.sv */
/*
 * Purely combinational steering of response words to the assemblers.
 * Words of a non-setup kind or outside all engine windows are consumed
 * at once. A kept word waits for its own assembler and stalls the
 * whole input meanwhile, so words never overtake each other.
 * The offset is used directly as a word index (no address shift).
 */
`include "cfg_loader_consts.svh"

module response_dispatcher (
    input  cfg_loader_pkg::response_word_t    resp,
    input  logic                              resp_valid,
    output logic                              resp_ready,
    output cfg_loader_pkg::setup_word_t       word,
    output logic [`CFG_NUM_ENGINES-1:0]       word_valid,
    input  logic [`CFG_NUM_ENGINES-1:0]       word_ready
);

    localparam int POS_W = $bits(cfg_loader_pkg::seq_pos_t);
    localparam int ENG_W = $bits(cfg_loader_pkg::engine_id_t);

    // First offset past the last engine window
    localparam cfg_loader_pkg::offset_t WIN_LIMIT =
        cfg_loader_pkg::offset_t'(`CFG_NUM_ENGINES * `CFG_SEQ_WIDTH);

    logic                       kind_ok;
    logic                       in_window;
    logic                       keep;
    cfg_loader_pkg::engine_id_t engine;
    cfg_loader_pkg::seq_pos_t   pos;

    // --------------------------------------------------
    // Push filter
    // --------------------------------------------------
    assign kind_ok   = (resp.kind == cfg_loader_pkg::KIND_CU_SETUP) ||
                       (resp.kind == cfg_loader_pkg::KIND_ENGINE_SETUP);
    assign in_window = (resp.offset < WIN_LIMIT);
    assign keep      = kind_ok && in_window;

    // Offset split, upper bits pick the engine
    assign pos    = resp.offset[POS_W-1:0];
    assign engine = resp.offset[POS_W +: ENG_W];

    assign word.pos  = pos;
    assign word.data = resp.data;

    // --------------------------------------------------
    // Steering
    // --------------------------------------------------
    always_comb begin
        for (int e = 0; e < `CFG_NUM_ENGINES; e++) begin
            word_valid[e] = resp_valid && keep &&
                            (engine == cfg_loader_pkg::engine_id_t'(e));
        end
    end

    // Dropped words are swallowed without waiting
    always_comb begin
        if (keep) begin
            resp_ready = word_ready[engine];
        end else begin
            resp_ready = 1'b1;
        end
    end

endmodule

/* config_assembler.sv */
/*
 * Collects the setup words of one engine into a configuration record.
 * Words must arrive in position order starting at position 0.
 * A position-0 word always starts a new record; any other word at an
 * unexpected position is dropped. No new words are taken while a
 * finished record waits for the arbiter.
 */
`include "cfg_loader_consts.svh"

module config_assembler (
    input  logic                           ap_clk,
    input  logic                           rst_n,
    input  cfg_loader_pkg::setup_word_t    word,
    input  logic                           word_valid,
    output logic                           word_ready,
    output cfg_loader_pkg::config_params_t params,
    output logic                           params_valid,
    input  logic                           params_ready
);

    localparam int N = `CFG_NUM_WORDS;

    // Word positions within the window
    localparam cfg_loader_pkg::seq_pos_t POS_FLAGS     = 0;
    localparam cfg_loader_pkg::seq_pos_t POS_IDX_START = 1;
    localparam cfg_loader_pkg::seq_pos_t POS_IDX_END   = 2;
    localparam cfg_loader_pkg::seq_pos_t POS_STRIDE    = 3;
    localparam cfg_loader_pkg::seq_pos_t POS_PTR_LO    = 4;
    localparam cfg_loader_pkg::seq_pos_t POS_PTR_HI    = 5;
    localparam cfg_loader_pkg::seq_pos_t POS_SIZE      = 6;

    localparam logic [N-1:0] POS_FIRST = 1;

    cfg_loader_pkg::asm_state_e state;
    logic [N-1:0]               pos_oh;
    logic [N-1:0]               pos_dec;
    logic [N-1:0]               eff_oh;
    logic [N-1:0]               next_oh;
    logic                       hit;
    logic                       take;
    logic                       last;

    assign word_ready   = (state == cfg_loader_pkg::ASM_COLLECT);
    assign params_valid = (state == cfg_loader_pkg::ASM_HOLD);

    // --------------------------------------------------
    // Position match
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < N; i++) begin
            pos_dec[i] = (word.pos == cfg_loader_pkg::seq_pos_t'(i));
        end
    end

    // Position 0 restarts, so it is always expected
    assign eff_oh  = pos_dec[0] ? POS_FIRST : pos_oh;
    assign hit     = |(pos_dec & eff_oh);
    assign take    = word_valid && word_ready && hit;
    assign last    = eff_oh[N-1];
    assign next_oh = {eff_oh[N-2:0], eff_oh[N-1]};

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            state  <= cfg_loader_pkg::ASM_COLLECT;
            pos_oh <= POS_FIRST;
        end else begin
            case (state)
                cfg_loader_pkg::ASM_COLLECT: begin
                    if (take) begin
                        // Rotation wraps back to position 0 on the last word
                        pos_oh <= next_oh;
                        if (last) begin
                            state <= cfg_loader_pkg::ASM_HOLD;
                        end
                    end
                end
                cfg_loader_pkg::ASM_HOLD: begin
                    if (params_ready) begin
                        state <= cfg_loader_pkg::ASM_COLLECT;
                    end
                end
                default: begin
                    state <= cfg_loader_pkg::ASM_COLLECT;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Field packing
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (take) begin
            case (word.pos)
                POS_FLAGS:     params.flags <= word.data[`CFG_FLAGS_W-1:0];
                POS_IDX_START: params.index_start <= word.data;
                POS_IDX_END:   params.index_end <= word.data;
                POS_STRIDE:    params.stride <= word.data;
                POS_PTR_LO:    params.array_ptr[`CFG_DATA_W-1:0] <= word.data;
                POS_PTR_HI:    params.array_ptr[2*`CFG_DATA_W-1:`CFG_DATA_W] <= word.data;
                POS_SIZE:      params.array_size <= word.data;
                default: begin
                end
            endcase
        end
    end

endmodule

/* config_arbiter.sv */
/*
 * Round-robin merge of finished records onto one registered output.
 * The pointer names the engine with top priority and moves past each
 * granted engine. Only one params_ready is high in any cycle, and a
 * record is taken only when the output register is free or draining.
 */
`include "cfg_loader_consts.svh"

module config_arbiter (
    input  logic                           ap_clk,
    input  logic                           rst_n,
    input  cfg_loader_pkg::config_params_t params [`CFG_NUM_ENGINES],
    input  logic [`CFG_NUM_ENGINES-1:0]    params_valid,
    output logic [`CFG_NUM_ENGINES-1:0]    params_ready,
    output cfg_loader_pkg::config_record_t cfg,
    output logic                           cfg_valid,
    input  logic                           cfg_ready
);

    localparam int N = `CFG_NUM_ENGINES;

    cfg_loader_pkg::engine_id_t ptr;
    cfg_loader_pkg::engine_id_t grant_id;
    logic                       grant_found;
    logic                       load;

    // Output register free or emptied this cycle
    assign load = !cfg_valid || cfg_ready;

    // --------------------------------------------------
    // Round-robin grant
    // --------------------------------------------------
    always_comb begin
        int cand;
        grant_found = 1'b0;
        grant_id    = ptr;
        for (int i = 0; i < N; i++) begin
            cand = (int'(ptr) + i) % N;
            if (!grant_found && params_valid[cand]) begin
                grant_found = 1'b1;
                grant_id    = cfg_loader_pkg::engine_id_t'(cand);
            end
        end
    end

    always_comb begin
        for (int e = 0; e < N; e++) begin
            params_ready[e] = load && grant_found &&
                              (grant_id == cfg_loader_pkg::engine_id_t'(e));
        end
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            cfg_valid <= 1'b0;
            ptr       <= '0;
        end else if (load) begin
            cfg_valid <= grant_found;
            if (grant_found) begin
                ptr <= cfg_loader_pkg::engine_id_t'((int'(grant_id) + 1) % N);
            end
        end
    end

    // Tag the record with the granted engine
    always_ff @(posedge ap_clk) begin
        if (load && grant_found) begin
            cfg.engine <= grant_id;
            cfg.params <= params[grant_id];
        end
    end

endmodule

/* cfg_loader_top.sv */
/*
 * Setup-word loader: dispatcher, one assembler per engine, arbiter.
 * Engine e owns offsets e*CFG_SEQ_WIDTH up to (e+1)*CFG_SEQ_WIDTH-1.
 * All ports use valid/ready; a stalled input word blocks all later
 * words until its assembler frees up.
 */
`include "cfg_loader_consts.svh"

module cfg_loader_top (
    input  logic                           ap_clk,
    input  logic                           rst_n,
    input  cfg_loader_pkg::response_word_t resp,
    input  logic                           resp_valid,
    output logic                           resp_ready,
    output cfg_loader_pkg::config_record_t cfg,
    output logic                           cfg_valid,
    input  logic                           cfg_ready
);

    cfg_loader_pkg::setup_word_t    word;
    logic [`CFG_NUM_ENGINES-1:0]    word_valid;
    logic [`CFG_NUM_ENGINES-1:0]    word_ready;
    cfg_loader_pkg::config_params_t params [`CFG_NUM_ENGINES];
    logic [`CFG_NUM_ENGINES-1:0]    params_valid;
    logic [`CFG_NUM_ENGINES-1:0]    params_ready;

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------
    response_dispatcher u_dispatcher (
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready)
    );

    // One assembler per engine, word bus shared
    for (genvar e = 0; e < `CFG_NUM_ENGINES; e++) begin : g_engine
        config_assembler u_assembler (
            .ap_clk       (ap_clk),
            .rst_n        (rst_n),
            .word         (word),
            .word_valid   (word_valid[e]),
            .word_ready   (word_ready[e]),
            .params       (params[e]),
            .params_valid (params_valid[e]),
            .params_ready (params_ready[e])
        );
    end

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    config_arbiter u_arbiter (
        .ap_clk       (ap_clk),
        .rst_n        (rst_n),
        .params       (params),
        .params_valid (params_valid),
        .params_ready (params_ready),
        .cfg          (cfg),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready)
    );

endmodule

/* tb_cfg_loader.sv */
/*
 * Random testbench for the setup-word loader.
 * Words are generated from a reference model with noise mixed in:
 * foreign kinds, offsets past the windows, random positions and restarts.
 * Records of one engine must arrive in order; engines may interleave.
 */
`include "cfg_loader_consts.svh"

module tb_cfg_loader;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD    = 4;
    localparam int          RESET_CYCLES  = 16;
    localparam int          NUM_RECORDS   = 40;
    localparam int          WORD_TIMEOUT  = 400;
    localparam int          DRAIN_TIMEOUT = 2000;
    localparam int          IDLE_TAIL     = 20;
    localparam logic [31:0] LFSR_SEED     = 32'd49;
    localparam logic [31:0] LFSR_TAPS     = 32'h8020_0003;
    localparam int          NUM_ENG       = `CFG_NUM_ENGINES;
    localparam int          SEQ_W         = `CFG_SEQ_WIDTH;
    localparam int          LAST_POS      = `CFG_NUM_WORDS - 1;

    logic                           ap_clk;
    logic                           rst_n;
    cfg_loader_pkg::response_word_t resp;
    logic                           resp_valid;
    logic                           resp_ready;
    cfg_loader_pkg::config_record_t cfg;
    logic                           cfg_valid;
    logic                           cfg_ready;

    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;

    // Reference model state
    cfg_loader_pkg::config_params_t part [NUM_ENG];
    int                             exp_pos [NUM_ENG];
    cfg_loader_pkg::config_record_t exp_q [$];
    int                             pushed;
    int                             received;

    cfg_loader_top DUT (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .cfg        (cfg),
        .cfg_valid  (cfg_valid),
        .cfg_ready  (cfg_ready)
    );

    initial begin
        ap_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Galois LFSR stepped once per returned bit
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++) begin
            bit_out = state[0];
            state   = state >> 1;
            if (bit_out) begin
                state = state ^ LFSR_TAPS;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            fail_run($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    // Drop, order and restart rules applied to one accepted word
    function automatic void model_word(input cfg_loader_pkg::response_word_t w);
        int                             e;
        int                             p;
        cfg_loader_pkg::config_record_t rec;
        if ((w.kind == cfg_loader_pkg::KIND_CU_SETUP ||
             w.kind == cfg_loader_pkg::KIND_ENGINE_SETUP) &&
            int'(w.offset) < NUM_ENG * SEQ_W) begin
            e = int'(w.offset) / SEQ_W;
            p = int'(w.offset) % SEQ_W;
            if (p == 0) begin
                exp_pos[e] = 0;
            end
            if (p == exp_pos[e]) begin
                case (p)
                    0: part[e].flags = w.data[`CFG_FLAGS_W-1:0];
                    1: part[e].index_start = w.data;
                    2: part[e].index_end = w.data;
                    3: part[e].stride = w.data;
                    4: part[e].array_ptr[31:0] = w.data;
                    5: part[e].array_ptr[63:32] = w.data;
                    default: part[e].array_size = w.data;
                endcase
                if (p == LAST_POS) begin
                    rec.engine = cfg_loader_pkg::engine_id_t'(e);
                    rec.params = part[e];
                    exp_q.push_back(rec);
                    pushed++;
                    exp_pos[e] = 0;
                end else begin
                    exp_pos[e] = p + 1;
                end
            end
        end
    endfunction

    // Called shortly after a rising edge and returns likewise
    task automatic send_word(input cfg_loader_pkg::response_word_t w);
        int   waited;
        logic taken;
        resp       = w;
        resp_valid = 1'b1;
        waited     = 0;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge ap_clk);
            taken = resp_ready;
            @(posedge ap_clk);
            if (!taken) begin
                waited++;
                assert (waited < WORD_TIMEOUT) else begin
                    fail_run("Timeout: an input word was never accepted");
                end
            end
        end
        model_word(w);
        #1;
        resp_valid = 1'b0;
    endtask

    task automatic check_record(input cfg_loader_pkg::config_record_t rec);
        int                             idx;
        cfg_loader_pkg::config_params_t want;
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i].engine == rec.engine) begin
                idx = i;
            end
        end
        assert (idx >= 0) else begin
            fail_run($sformatf("Unexpected record tagged with engine %0d", rec.engine));
        end
        want = exp_q[idx].params;
        exp_q.delete(idx);
        check_value("cfg.params.flags", 64'(rec.params.flags), 64'(want.flags));
        check_value("cfg.params.index_start", 64'(rec.params.index_start),
                    64'(want.index_start));
        check_value("cfg.params.index_end", 64'(rec.params.index_end), 64'(want.index_end));
        check_value("cfg.params.stride", 64'(rec.params.stride), 64'(want.stride));
        check_value("cfg.params.array_ptr", rec.params.array_ptr, want.array_ptr);
        check_value("cfg.params.array_size", 64'(rec.params.array_size),
                    64'(want.array_size));
        received++;
    endtask

    // --------------------------------------------------
    // Output side
    // --------------------------------------------------
    initial begin
        logic [31:0] bits;
        ready_lfsr = LFSR_SEED;
        cfg_ready  = 1'b0;
        forever begin
            @(posedge ap_clk);
            // Reset level is settled at the edge
            if (rst_n) begin
                #1;
                // Ready about three cycles in four
                bits      = take_bits(ready_lfsr, 2);
                cfg_ready = (bits != 0);
            end
        end
    end

    // Sampled at the falling edge before the transfer
    initial begin
        forever begin
            @(negedge ap_clk);
            if (rst_n && cfg_valid && cfg_ready) begin
                check_record(cfg);
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        cfg_loader_pkg::response_word_t w;
        int                             e;
        int                             sel;
        int                             waited;
        logic [31:0]                    bits;
        stim_lfsr  = LFSR_SEED;
        rst_n      = 1'b0;
        resp       = '0;
        resp_valid = 1'b0;
        pushed     = 0;
        received   = 0;
        for (int i = 0; i < NUM_ENG; i++) begin
            exp_pos[i] = 0;
            part[i]    = '0;
        end

        repeat (RESET_CYCLES) begin
            @(posedge ap_clk);
            #1;
            check_value("cfg_valid", 64'(cfg_valid), 64'(1'b0));
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge ap_clk);
            #1;
            check_value("cfg_valid", 64'(cfg_valid), 64'(1'b0));
        end

        while (pushed < NUM_RECORDS) begin
            e = int'(take_bits(stim_lfsr, 2));
            bits = take_bits(stim_lfsr, 1);
            if (bits == 0) begin
                w.kind = cfg_loader_pkg::KIND_CU_SETUP;
            end else begin
                w.kind = cfg_loader_pkg::KIND_ENGINE_SETUP;
            end
            w.offset = cfg_loader_pkg::offset_t'(e * SEQ_W + exp_pos[e]);
            w.data   = take_bits(stim_lfsr, 32);
            // One word in four is noise
            bits = take_bits(stim_lfsr, 2);
            if (bits == 0) begin
                sel = int'(take_bits(stim_lfsr, 2));
                case (sel)
                    0: begin
                        bits = take_bits(stim_lfsr, 2);
                        if (bits == 0) begin
                            w.kind = cfg_loader_pkg::KIND_NONE;
                        end else if (bits == 1) begin
                            w.kind = cfg_loader_pkg::KIND_VERTEX;
                        end else begin
                            w.kind = cfg_loader_pkg::KIND_EDGE;
                        end
                    end
                    1: begin
                        w.offset = cfg_loader_pkg::offset_t'(NUM_ENG * SEQ_W +
                                   int'(take_bits(stim_lfsr, 7)));
                    end
                    2: begin
                        w.offset = cfg_loader_pkg::offset_t'(e * SEQ_W +
                                   int'(take_bits(stim_lfsr, 3)));
                    end
                    default: begin
                        w.offset = cfg_loader_pkg::offset_t'(e * SEQ_W);
                    end
                endcase
            end
            send_word(w);
        end

        waited = 0;
        while (received < NUM_RECORDS) begin
            @(posedge ap_clk);
            waited++;
            assert (waited < DRAIN_TIMEOUT) else begin
                fail_run("Timeout: not all expected records came out");
            end
        end
        // Extra records in the idle tail fail in the monitor
        repeat (IDLE_TAIL) @(posedge ap_clk);

        if (exp_q.size() == 0 && received == NUM_RECORDS) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run("Record count does not match the reference model");
        end
    end

endmodule

/* project.f */
+incdir+.
cfg_loader_pkg.sv
response_dispatcher.sv
config_assembler.sv
config_arbiter.sv
cfg_loader_top.sv
tb_cfg_loader.sv

/* Makefile */
# Verilator build and run of the loader testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cfg_loader
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search the output for the pass line"
	@echo "  clean  remove the build folder"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
